/* flist.f */
hw/join_pkg.sv
hw/stream_if.sv
hw/join_sequencer.sv
hw/byte_merge.sv
hw/out_stage.sv
hw/stream_join.sv
tests/stream_join_assertions.sv
tests/tb_stream_join.sv

/* tests/tb_stream_join.sv */
// tb_stream_join: table-driven testbench for the header and payload stream joiner.

`timescale 1ns/1ps

module tb_stream_join;
   import join_pkg::*;

   localparam int clk_period   = 20;
   localparam int reset_cycles = 8;
   localparam int n_rows       = 18;

   // each row holds header bytes, payload bytes, stall percent and enable-low cycles.
   int stim [n_rows][4] = '{
      '{ 8, 20,  0, 0}, '{16,  8,  0, 0}, '{11, 13,  0, 0}, '{ 3, 20,  0, 0},
      '{ 6,  5,  0, 0}, '{13, 15,  0, 0}, '{ 3,  4,  0, 0}, '{ 4,  4,  0, 0},
      '{ 1,  1,  0, 0}, '{ 8,  8, 40, 0}, '{ 7,  9, 50, 0}, '{24, 17, 30, 0},
      '{ 5, 30, 60, 0}, '{ 2,  7, 45, 0}, '{15, 15, 75, 0}, '{ 9, 40, 35, 0},
      '{ 6, 11, 20, 4}, '{ 8,  3, 50, 3}
   };

   logic                  clk = 1'b0;
   logic                  resetn;
   logic                  enable;
   logic [data_bits-1:0]  hdr_data;
   logic [data_bytes-1:0] hdr_keep;
   logic                  hdr_last;
   logic                  hdr_valid;
   logic                  hdr_ready;
   logic [data_bits-1:0]  pyld_data;
   logic [data_bytes-1:0] pyld_keep;
   logic                  pyld_last;
   logic                  pyld_valid;
   logic                  pyld_ready;
   logic [data_bits-1:0]  out_data;
   logic [data_bytes-1:0] out_keep;
   logic                  out_last;
   logic                  out_valid;
   logic                  out_ready;

   // words waiting for the drivers, and the words the output should carry.
   logic [data_bits-1:0]  hdr_data_q [$];
   logic [data_bytes-1:0] hdr_keep_q [$];
   logic                  hdr_last_q [$];
   logic [data_bits-1:0]  pyld_data_q [$];
   logic [data_bytes-1:0] pyld_keep_q [$];
   logic                  pyld_last_q [$];
   logic [data_bits-1:0]  exp_data_q [$];
   logic [data_bytes-1:0] exp_keep_q [$];
   logic                  exp_last_q [$];
   logic [7:0]            row_bytes [$];

   int errors     = 0;
   int rows_done  = 0;
   int words_seen = 0;
   int row_words  = 0;
   int row_errors = 0;

   stream_join u_stream_join (
      .clk        (clk),
      .resetn     (resetn),
      .enable     (enable),
      .hdr_data   (hdr_data),
      .hdr_keep   (hdr_keep),
      .hdr_last   (hdr_last),
      .hdr_valid  (hdr_valid),
      .hdr_ready  (hdr_ready),
      .pyld_data  (pyld_data),
      .pyld_keep  (pyld_keep),
      .pyld_last  (pyld_last),
      .pyld_valid (pyld_valid),
      .pyld_ready (pyld_ready),
      .out_data   (out_data),
      .out_keep   (out_keep),
      .out_last   (out_last),
      .out_valid  (out_valid),
      .out_ready  (out_ready)
   );

   bind stream_join stream_join_assertions u_stream_join_assertions (
      .clk       (clk),
      .resetn    (resetn),
      .out_data  (out_data),
      .out_keep  (out_keep),
      .out_last  (out_last),
      .out_valid (out_valid),
      .out_ready (out_ready)
   );

   always #(clk_period / 2) clk = ~clk;

   task automatic report_mismatch(input string name, input logic [data_bits-1:0] expected,
                                  input logic [data_bits-1:0] actual);
      $display("Mismatch at %0t ns: %s expected %0h got %0h", $time, name, expected, actual);
      errors++;
      row_errors++;
   endtask

   task automatic report_failure(input string what);
      $display("Error at %0t ns: %s", $time, what);
      errors++;
      row_errors++;
   endtask

   // ------------------------------------------------------------
   // stimulus and reference model.
   // ------------------------------------------------------------
   // split n random bytes into words, all full except the last.
   task automatic load_packet(input int n, input bit is_hdr);
      logic [data_bits-1:0]  word;
      logic [data_bytes-1:0] keep;
      int                    lanes;
      for (int base = 0; base < n; base += data_bytes) begin
         // lanes above keep carry junk that must never reach the output.
         word  = {$urandom, $urandom};
         lanes = (n - base < data_bytes) ? n - base : data_bytes;
         keep  = '0;
         for (int i = 0; i < lanes; i++) begin
            keep[i] = 1'b1;
            row_bytes.push_back(word[i*8 +: 8]);
         end
         if (is_hdr) begin
            hdr_data_q.push_back(word);
            hdr_keep_q.push_back(keep);
            hdr_last_q.push_back(base + data_bytes >= n);
         end else begin
            pyld_data_q.push_back(word);
            pyld_keep_q.push_back(keep);
            pyld_last_q.push_back(base + data_bytes >= n);
         end
      end
   endtask

   // header bytes then payload bytes, densely packed from lane 0.
   task automatic expect_row();
      logic [data_bits-1:0]  word;
      logic [data_bytes-1:0] keep;
      int                    n;
      n = row_bytes.size();
      for (int base = 0; base < n; base += data_bytes) begin
         word = '0;
         keep = '0;
         for (int i = 0; i < data_bytes && base + i < n; i++) begin
            word[i*8 +: 8] = row_bytes[base + i];
            keep[i]        = 1'b1;
         end
         exp_data_q.push_back(word);
         exp_keep_q.push_back(keep);
         exp_last_q.push_back(base + data_bytes >= n);
      end
      row_bytes.delete();
   endtask

   task automatic check_word();
      logic [data_bits-1:0]  mask;
      logic [data_bits-1:0]  exp_data;
      logic [data_bytes-1:0] exp_keep;
      logic                  exp_last;
      if (exp_data_q.size() == 0) begin
         report_failure("output word arrived when no word was expected");
         return;
      end
      exp_data = exp_data_q.pop_front();
      exp_keep = exp_keep_q.pop_front();
      exp_last = exp_last_q.pop_front();
      for (int i = 0; i < data_bytes; i++) begin
         mask[i*8 +: 8] = {8{exp_keep[i]}};
      end
      words_seen++;
      row_words++;
      if (out_keep !== exp_keep) report_mismatch("out_keep", exp_keep, out_keep);
      if (out_last !== exp_last) report_mismatch("out_last", exp_last, out_last);
      if ((out_data & mask) !== (exp_data & mask)) begin
         report_mismatch("out_data", exp_data & mask, out_data & mask);
      end
      if (exp_last) begin
         $display("row %0d: header %0d bytes, payload %0d bytes, %0d words, %0d errors",
                  rows_done, stim[rows_done][0], stim[rows_done][1], row_words, row_errors);
         rows_done++;
         row_words  = 0;
         row_errors = 0;
      end
   endtask

   // drain earlier rows, then hold enable low between packets.
   task automatic pulse_enable(input int r);
      while (rows_done < r) @(negedge clk);
      repeat (2) @(negedge clk);
      enable = 1'b0;
      repeat (stim[r][3]) @(negedge clk);
      if (out_valid || hdr_ready || pyld_ready) begin
         report_failure("out_valid or an input ready stayed high while enable was low");
      end
      enable = 1'b1;
   endtask

   function automatic longint row_cycles(input int r);
      longint words;
      words = (stim[r][0] + data_bytes - 1) / data_bytes
            + (stim[r][1] + data_bytes - 1) / data_bytes + 1;
      return (words + stim[r][3] + 8) * 100 / (100 - stim[r][2]);
   endfunction

   // ------------------------------------------------------------
   // drivers, output monitor and watchdog.
   // ------------------------------------------------------------
   // readies only move on rising edges, so the negedge value decides the handshake.
   initial begin : drive_header
      forever begin
         @(negedge clk);
         if (hdr_data_q.size() == 0) begin
            hdr_valid = 1'b0;
         end else begin
            hdr_data  = hdr_data_q.pop_front();
            hdr_keep  = hdr_keep_q.pop_front();
            hdr_last  = hdr_last_q.pop_front();
            hdr_valid = 1'b1;
            while (!hdr_ready) @(negedge clk);
         end
      end
   end

   initial begin : drive_payload
      forever begin
         @(negedge clk);
         if (pyld_data_q.size() == 0) begin
            pyld_valid = 1'b0;
         end else begin
            pyld_data  = pyld_data_q.pop_front();
            pyld_keep  = pyld_keep_q.pop_front();
            pyld_last  = pyld_last_q.pop_front();
            pyld_valid = 1'b1;
            while (!pyld_ready) @(negedge clk);
         end
      end
   end

   initial begin : check_output
      int stall;
      forever begin
         @(negedge clk);
         stall     = (rows_done < n_rows) ? stim[rows_done][2] : 0;
         out_ready = ($urandom_range(99) >= stall);
         // a word shown now moves on the next rising edge.
         if (out_valid && out_ready) check_word();
      end
   end

   initial begin : watchdog
      longint longest;
      longint limit;
      longest = 0;
      for (int r = 0; r < n_rows; r++) begin
         if (row_cycles(r) > longest) longest = row_cycles(r);
      end
      limit = (n_rows * longest * 4 + reset_cycles) * clk_period;
      #(limit);
      $display("Timeout: only %0d of %0d rows finished within %0d ns", rows_done, n_rows, limit);
      $display("Result: FAILED");
      $finish;
   end

   initial begin : run_table
      void'($urandom(24633));
      resetn     = 1'b0;
      enable     = 1'b1;
      hdr_data   = '0;
      hdr_keep   = '0;
      hdr_last   = 1'b0;
      hdr_valid  = 1'b0;
      pyld_data  = '0;
      pyld_keep  = '0;
      pyld_last  = 1'b0;
      pyld_valid = 1'b0;
      out_ready  = 1'b0;
      repeat (reset_cycles) @(negedge clk);
      if (out_valid || hdr_ready || pyld_ready) report_failure("outputs not low during reset");
      resetn = 1'b1;
      for (int r = 0; r < n_rows; r++) begin
         if (stim[r][3] > 0) pulse_enable(r);
         load_packet(stim[r][0], 1'b1);
         load_packet(stim[r][1], 1'b0);
         expect_row();
      end
      while (rows_done < n_rows) @(negedge clk);
      // idle a while so a stray extra word is still caught.
      repeat (10) @(negedge clk);
      errors += u_stream_join.u_stream_join_assertions.fail_count;
      $display("rows %0d of %0d, words %0d, errors %0d", rows_done, n_rows, words_seen, errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

/* tests/stream_join_assertions.sv */
// stream_join_assertions: handshake and reset properties on the joined output stream.

`timescale 1ns/1ps

module stream_join_assertions (
   input logic                           clk,
   input logic                           resetn,
   input logic [join_pkg::data_bits-1:0]  out_data,
   input logic [join_pkg::data_bytes-1:0] out_keep,
   input logic                           out_last,
   input logic                           out_valid,
   input logic                           out_ready
);

   // failed assertions so far, read by the testbench at the end of the run.
   int fail_count = 0;

   // a stalled word stays put until the sink takes it.
   hold_while_stalled: assert property (@(posedge clk) disable iff (!resetn)
      (out_valid && !out_ready) |=> ($stable(out_data) && $stable(out_keep) && $stable(out_last))
   ) else begin
      fail_count++;
      $error("output word changed while out_ready was low");
   end

   keep_not_empty: assert property (@(posedge clk) disable iff (!resetn)
      out_valid |-> (out_keep != '0)
   ) else begin
      fail_count++;
      $error("out_keep is zero on a valid word");
   end

   // reset is synchronous, so out_valid is low one edge later.
   quiet_in_reset: assert property (@(posedge clk) !resetn |=> !out_valid) else begin
      fail_count++;
      $error("out_valid high while in reset");
   end

endmodule

/* hw/stream_join.sv */
// stream_join: rejoins a header stream and a payload stream into one packed packet stream.

`timescale 1ns/1ps

module stream_join (
   input  logic                           clk,
   input  logic                           resetn,
   input  logic                           enable,

   input  logic [join_pkg::data_bits-1:0]  hdr_data,
   input  logic [join_pkg::data_bytes-1:0] hdr_keep,
   input  logic                           hdr_last,
   input  logic                           hdr_valid,
   output logic                           hdr_ready,

   input  logic [join_pkg::data_bits-1:0]  pyld_data,
   input  logic [join_pkg::data_bytes-1:0] pyld_keep,
   input  logic                           pyld_last,
   input  logic                           pyld_valid,
   output logic                           pyld_ready,

   output logic [join_pkg::data_bits-1:0]  out_data,
   output logic [join_pkg::data_bytes-1:0] out_keep,
   output logic                           out_last,
   output logic                           out_valid,
   input  logic                           out_ready
);
   import join_pkg::*;

   logic                  clear_n;
   logic                  load_residue;
   logic                  advance;
   logic                  clear_tail;
   logic [data_bits-1:0]  merged_data;
   logic [data_bytes-1:0] merged_keep;
   logic                  overflow;
   logic                  residue_empty;
   logic [data_bits-1:0]  tail_data;
   logic [data_bytes-1:0] tail_keep;

   stream_if join_word ();

   // enable low acts as a synchronous clear.
   assign clear_n = resetn && enable;

   join_sequencer u_join_sequencer (
      .clk           (clk),
      .resetn        (clear_n),
      .hdr_data      (hdr_data),
      .hdr_keep      (hdr_keep),
      .hdr_last      (hdr_last),
      .hdr_valid     (hdr_valid),
      .hdr_ready     (hdr_ready),
      .pyld_keep     (pyld_keep),
      .pyld_last     (pyld_last),
      .pyld_valid    (pyld_valid),
      .pyld_ready    (pyld_ready),
      .merged_data   (merged_data),
      .merged_keep   (merged_keep),
      .overflow      (overflow),
      .residue_empty (residue_empty),
      .tail_data     (tail_data),
      .tail_keep     (tail_keep),
      .load_residue  (load_residue),
      .advance       (advance),
      .clear_tail    (clear_tail),
      .join_word     (join_word.src)
   );

   byte_merge u_byte_merge (
      .clk           (clk),
      .resetn        (clear_n),
      .hdr_data      (hdr_data),
      .hdr_keep      (hdr_keep),
      .load_residue  (load_residue),
      .pyld_data     (pyld_data),
      .pyld_keep     (pyld_keep),
      .advance       (advance),
      .clear_tail    (clear_tail),
      .merged_data   (merged_data),
      .merged_keep   (merged_keep),
      .overflow      (overflow),
      .residue_empty (residue_empty),
      .tail_data     (tail_data),
      .tail_keep     (tail_keep)
   );

   out_stage u_out_stage (
      .clk       (clk),
      .resetn    (clear_n),
      .join_word (join_word.dst),
      .out_data  (out_data),
      .out_keep  (out_keep),
      .out_last  (out_last),
      .out_valid (out_valid),
      .out_ready (out_ready)
   );

endmodule

/* hw/out_stage.sv */
// out_stage: two-entry register pipe that isolates output back-pressure from the join logic.

`timescale 1ns/1ps

module out_stage (
   input  logic                           clk,
   input  logic                           resetn,

   stream_if.dst                          join_word,

   output logic [join_pkg::data_bits-1:0]  out_data,
   output logic [join_pkg::data_bytes-1:0] out_keep,
   output logic                           out_last,
   output logic                           out_valid,
   input  logic                           out_ready
);
   import join_pkg::*;

   logic [data_bits-1:0]  skid_data;
   logic [data_bytes-1:0] skid_keep;
   logic                  skid_last;
   logic                  skid_valid;
   logic                  ready_q;
   logic                  push;
   logic                  out_free;
   logic                  out_valid_d;
   logic                  skid_valid_d;

   // ready is a flop, so out_ready never reaches the input readies.
   assign join_word.ready = ready_q;
   assign push            = join_word.valid && ready_q;
   assign out_free        = !out_valid || out_ready;

   always_comb begin
      out_valid_d  = out_valid;
      skid_valid_d = skid_valid;
      if (out_free) begin
         // the skid entry is older, so it leaves first.
         out_valid_d  = skid_valid || push;
         skid_valid_d = 1'b0;
      end else if (push) begin
         skid_valid_d = 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         out_valid  <= 1'b0;
         skid_valid <= 1'b0;
         ready_q    <= 1'b0;
      end else begin
         out_valid  <= out_valid_d;
         skid_valid <= skid_valid_d;
         ready_q    <= !skid_valid_d;
      end
   end

   always_ff @(posedge clk) begin
      if (out_free && skid_valid) begin
         out_data <= skid_data;
         out_keep <= skid_keep;
         out_last <= skid_last;
      end else if (out_free && push) begin
         out_data <= join_word.data;
         out_keep <= join_word.keep;
         out_last <= join_word.last;
      end
      if (!out_free && push) begin
         skid_data <= join_word.data;
         skid_keep <= join_word.keep;
         skid_last <= join_word.last;
      end
   end

endmodule

/* hw/byte_merge.sv */
// byte_merge: residue register and byte-lane merge of the header residue with payload words.

`timescale 1ns/1ps

module byte_merge (
   input  logic                           clk,
   input  logic                           resetn,

   input  logic [join_pkg::data_bits-1:0]  hdr_data,
   input  logic [join_pkg::data_bytes-1:0] hdr_keep,
   input  logic                           load_residue,

   input  logic [join_pkg::data_bits-1:0]  pyld_data,
   input  logic [join_pkg::data_bytes-1:0] pyld_keep,
   input  logic                           advance,
   input  logic                           clear_tail,

   output logic [join_pkg::data_bits-1:0]  merged_data,
   output logic [join_pkg::data_bytes-1:0] merged_keep,
   output logic                           overflow,
   output logic                           residue_empty,
   output logic [join_pkg::data_bits-1:0]  tail_data,
   output logic [join_pkg::data_bytes-1:0] tail_keep
);
   import join_pkg::*;

   logic [data_bits-1:0]  residue_data;
   logic [count_bits-1:0] residue_cnt;
   logic [count_bits-1:0] hdr_cnt;
   logic [count_bits-1:0] pyld_cnt;
   logic [count_bits:0]   total_cnt;
   logic [data_bits-1:0]  pyld_up;
   logic [data_bits-1:0]  pyld_rest;

   assign hdr_cnt   = keep_to_count(hdr_keep);
   assign pyld_cnt  = keep_to_count(pyld_keep);
   assign total_cnt = {1'b0, residue_cnt} + {1'b0, pyld_cnt};
   assign overflow  = (total_cnt > data_bytes);

   // ------------------------------------------------------------
   // lane steering.
   // ------------------------------------------------------------
   // payload moves up by r lanes, bytes pushed past the top are kept.
   assign pyld_up   = pyld_data << (residue_cnt * 8);
   assign pyld_rest = pyld_data >> ((data_bytes - residue_cnt) * 8);

   assign merged_data = merge_bytes(residue_cnt, residue_data, pyld_up);
   assign merged_keep = overflow ? '1 : count_to_keep(total_cnt[count_bits-1:0]);

   // after an overflowing last word the residue is the tail.
   assign residue_empty = (residue_cnt == '0);
   assign tail_data     = residue_data;
   assign tail_keep     = count_to_keep(residue_cnt);

   // ------------------------------------------------------------
   // residue register.
   // ------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (!resetn) begin
         residue_cnt <= '0;
      end else if (load_residue) begin
         // a full last header word leaves nothing to carry.
         residue_cnt <= (hdr_cnt == data_bytes) ? '0 : hdr_cnt;
      end else if (advance) begin
         // full words carry r bytes on; a last word that fits empties it.
         residue_cnt <= overflow ? count_bits'(total_cnt - data_bytes) : '0;
      end else if (clear_tail) begin
         residue_cnt <= '0;
      end
   end

   always_ff @(posedge clk) begin
      if (load_residue) begin
         residue_data <= hdr_data;
      end else if (advance) begin
         residue_data <= pyld_rest;
      end
   end

endmodule

/* hw/join_sequencer.sv */
// join_sequencer: FSM that walks header, payload and tail words and steers the input readies.

`timescale 1ns/1ps

module join_sequencer (
   input  logic                           clk,
   input  logic                           resetn,

   input  logic [join_pkg::data_bits-1:0]  hdr_data,
   input  logic [join_pkg::data_bytes-1:0] hdr_keep,
   input  logic                           hdr_last,
   input  logic                           hdr_valid,
   output logic                           hdr_ready,

   input  logic [join_pkg::data_bytes-1:0] pyld_keep,
   input  logic                           pyld_last,
   input  logic                           pyld_valid,
   output logic                           pyld_ready,

   input  logic [join_pkg::data_bits-1:0]  merged_data,
   input  logic [join_pkg::data_bytes-1:0] merged_keep,
   input  logic                           overflow,
   input  logic                           residue_empty,
   input  logic [join_pkg::data_bits-1:0]  tail_data,
   input  logic [join_pkg::data_bytes-1:0] tail_keep,

   output logic                           load_residue,
   output logic                           advance,
   output logic                           clear_tail,

   stream_if.src                          join_word
);
   import join_pkg::*;

   typedef enum logic [1:0] {
      st_header,
      st_payload,
      st_tail
   } state_t;

   state_t state;
   state_t state_d;
   logic   hdr_partial;

   // a short last header word stays behind as residue.
   assign hdr_partial = hdr_last && (keep_to_count(hdr_keep) != count_bits'(data_bytes));

   // ------------------------------------------------------------
   // next state and output steering.
   // ------------------------------------------------------------
   always_comb begin
      state_d         = state;
      hdr_ready       = 1'b0;
      pyld_ready      = 1'b0;
      load_residue    = 1'b0;
      advance         = 1'b0;
      clear_tail      = 1'b0;
      join_word.valid = 1'b0;
      join_word.data  = hdr_data;
      join_word.keep  = hdr_keep;
      join_word.last  = 1'b0;

      case (state)
         st_header: begin
            hdr_ready       = join_word.ready;
            join_word.valid = hdr_valid && !hdr_partial;
            if (hdr_valid && join_word.ready && hdr_last) begin
               load_residue = 1'b1;
               state_d      = st_payload;
            end
         end
         st_payload: begin
            pyld_ready      = join_word.ready;
            join_word.valid = pyld_valid;
            join_word.data  = merged_data;
            join_word.keep  = merged_keep;
            join_word.last  = pyld_last && !overflow;
            if (pyld_valid && join_word.ready) begin
               advance = 1'b1;
               if (pyld_last) begin
                  state_d = overflow ? st_tail : st_header;
               end
            end
         end
         st_tail: begin
            // the leftover payload bytes need no input word.
            join_word.valid = 1'b1;
            join_word.data  = tail_data;
            join_word.keep  = tail_keep;
            join_word.last  = 1'b1;
            if (join_word.ready) begin
               clear_tail = 1'b1;
               state_d    = st_header;
            end
         end
         default: state_d = st_header;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         state <= st_header;
      end else begin
         state <= state_d;
      end
   end

endmodule

/* hw/stream_if.sv */
// stream_if: one byte stream with data, keep, last and a valid/ready handshake.

`timescale 1ns/1ps

interface stream_if;
   import join_pkg::*;

   logic [data_bits-1:0]  data;
   logic [data_bytes-1:0] keep;
   logic                  last;
   logic                  valid;
   logic                  ready;

   // a word moves on a clock edge with valid and ready both high.
   modport src (
      output data, keep, last, valid,
      input  ready
   );

   modport dst (
      input  data, keep, last, valid,
      output ready
   );

endinterface

/* hw/join_pkg.sv */
// join_pkg: stream width constants and byte-lane helper functions for the stream joiner.

package join_pkg;

   // ------------------------------------------------------------
   // stream geometry.
   // ------------------------------------------------------------
   localparam int data_bytes = 8;
   localparam int data_bits  = data_bytes * 8;
   // counts run from 0 to data_bytes inclusive.
   localparam int count_bits = $clog2(data_bytes + 1);

   // number of valid bytes in a low-aligned keep.
   function automatic logic [count_bits-1:0] keep_to_count(input logic [data_bytes-1:0] keep);
      logic [count_bits-1:0] cnt;
      cnt = '0;
      for (int i = 0; i < data_bytes; i++) begin
         if (keep[i]) cnt = count_bits'(i + 1);
      end
      return cnt;
   endfunction

   // keep with the lowest n lanes set.
   function automatic logic [data_bytes-1:0] count_to_keep(input logic [count_bits-1:0] n);
      logic [data_bytes-1:0] keep;
      for (int i = 0; i < data_bytes; i++) begin
         keep[i] = (i < n);
      end
      return keep;
   endfunction

   // lanes below n come from lo, the rest from hi.
   function automatic logic [data_bits-1:0] merge_bytes(input logic [count_bits-1:0] n,
                                                        input logic [data_bits-1:0]  lo,
                                                        input logic [data_bits-1:0]  hi);
      logic [data_bits-1:0] word;
      for (int i = 0; i < data_bytes; i++) begin
         word[i*8 +: 8] = (i < n) ? lo[i*8 +: 8] : hi[i*8 +: 8];
      end
      return word;
   endfunction

endpackage
